/* Bender.yml */
package:
  name: seq_est

sources:
  - chan_pkg.sv
  - sym_pkg.sv
  - delay_line.sv
  - block_framer.sv
  - symbol_estimator_stub.sv
  - symbol_collector.sv
  - seq_est_top.sv
  - target: simulation
    files:
      - tb_seq_est.sv

/* block_framer.sv */
`timescale 1ns/1ps

module block_framer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sample_valid,
    input  sym_pkg::sample_t       sample,
    input  logic                   frame_start,
    output sym_pkg::sample_block_t rse_vals,
    output logic                   run,
    output logic                   initialize,
    output logic                   frame_end,
    output chan_pkg::pos_t         frame_position
);
    import chan_pkg::*;
    import sym_pkg::*;

    sample_block_t lane_buf;
    sample_block_t blk_next;
    lane_t         lane_cnt;
    lane_t         cur_lane;
    pos_t          blk_cnt;
    pos_t          cur_blk;
    logic          in_frame;
    logic          accept;
    logic          blk_done;
    logic          last_blk;

    // frame_start restarts lane and block count on the same strobe.
    assign accept   = sample_valid && (in_frame || frame_start);
    assign cur_lane = frame_start ? '0 : lane_cnt;
    assign cur_blk  = frame_start ? '0 : blk_cnt;
    assign blk_done = accept && (cur_lane == lane_t'(B_LEN - 1));
    assign last_blk = (cur_blk == pos_t'(NUM_BLOCKS - 1));

    always_comb begin
        blk_next           = lane_buf;
        blk_next[cur_lane] = sample;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_frame       <= 1'b0;
            lane_cnt       <= '0;
            blk_cnt        <= '0;
            run            <= 1'b0;
            initialize     <= 1'b0;
            frame_end      <= 1'b0;
            frame_position <= '0;
        end else begin
            run        <= blk_done && (cur_blk != '0);
            initialize <= blk_done && (cur_blk == '0);
            if (frame_start) begin
                in_frame <= 1'b1;
                lane_cnt <= '0;
                blk_cnt  <= '0;
            end
            if (accept) begin
                if (blk_done) begin
                    lane_cnt       <= '0;
                    blk_cnt        <= cur_blk + 1'b1;
                    frame_end      <= last_blk;  // held until the next block.
                    frame_position <= cur_blk;
                    if (last_blk) begin
                        in_frame <= 1'b0;  // drop samples until next start.
                    end
                end else begin
                    lane_cnt <= cur_lane + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_buf <= blk_next;
        end
        if (blk_done) begin
            rse_vals <= blk_next;
        end
    end

endmodule

/* build.f */
chan_pkg.sv
sym_pkg.sv
delay_line.sv
block_framer.sv
symbol_estimator_stub.sv
symbol_collector.sv
seq_est_top.sv
tb_seq_est.sv

/* chan_pkg.sv */
package chan_pkg;

    // frame geometry.
    localparam int NUM_BLOCKS = 40;
    localparam int POS_W      = $clog2(NUM_BLOCKS);

    // block index inside a frame.
    typedef logic [POS_W-1:0] pos_t;

endpackage

/* delay_line.sv */
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    payload_t stage [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            // shift toward the output.
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

/* seq_est_top.sv */
`timescale 1ns/1ps

module seq_est_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  sample_valid,
    input  sym_pkg::sample_t                      sample,
    input  logic                                  frame_start,
    output logic                                  sym_valid,
    output logic [$bits(sym_pkg::sym_block_t)-1:0] sym_word,
    output chan_pkg::pos_t                        sym_position,
    output logic                                  frame_done,
    output logic [chan_pkg::POS_W:0]              frame_blocks
);
    import chan_pkg::*;
    import sym_pkg::*;

    sample_block_t rse_vals;
    logic          run;
    logic          initialize;
    logic          frame_end;
    pos_t          frame_position;

    sym_block_t    final_symbols;
    logic          delayed_run;
    logic          delayed_initialize;
    logic          delayed_frame_end;
    pos_t          delayed_frame_position;

    block_framer u_framer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid   (sample_valid),
        .sample         (sample),
        .frame_start    (frame_start),
        .rse_vals       (rse_vals),
        .run            (run),
        .initialize     (initialize),
        .frame_end      (frame_end),
        .frame_position (frame_position)
    );

    symbol_estimator_stub u_est (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .rse_vals               (rse_vals),
        .run                    (run),
        .initialize             (initialize),
        .frame_end              (frame_end),
        .frame_position         (frame_position),
        .final_symbols          (final_symbols),
        .delayed_run            (delayed_run),
        .delayed_initialize     (delayed_initialize),
        .delayed_frame_end      (delayed_frame_end),
        .delayed_frame_position (delayed_frame_position)
    );

    symbol_collector u_coll (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .final_symbols          (final_symbols),
        .delayed_run            (delayed_run),
        .delayed_initialize     (delayed_initialize),
        .delayed_frame_end      (delayed_frame_end),
        .delayed_frame_position (delayed_frame_position),
        .sym_valid              (sym_valid),
        .sym_word               (sym_word),
        .sym_position           (sym_position),
        .frame_done             (frame_done),
        .frame_blocks           (frame_blocks)
    );

endmodule

/* sym_pkg.sv */
package sym_pkg;

    localparam int B_LEN   = 2;  // lanes per block.
    localparam int B_WIDTH = 8;  // soft sample width.
    localparam int H_DEPTH = 6;  // estimator latency in cycles.
    localparam int LANE_W  = $clog2(B_LEN);

    typedef logic [LANE_W-1:0] lane_t;

    typedef logic signed [B_WIDTH-1:0] sample_t;
    typedef sample_t [B_LEN-1:0] sample_block_t;

    // decided symbol, -2, 0 or +2.
    typedef logic signed [2:0] sym_t;
    typedef sym_t [B_LEN-1:0] sym_block_t;

    localparam sym_t SYM_FIRST = 3'sd2;  // first block of a frame.

endpackage

/* symbol_collector.sv */
`timescale 1ns/1ps

module symbol_collector (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  sym_pkg::sym_block_t                   final_symbols,
    input  logic                                  delayed_run,
    input  logic                                  delayed_initialize,
    input  logic                                  delayed_frame_end,
    input  chan_pkg::pos_t                        delayed_frame_position,
    output logic                                  sym_valid,
    output logic [$bits(sym_pkg::sym_block_t)-1:0] sym_word,
    output chan_pkg::pos_t                        sym_position,
    output logic                                  frame_done,
    output logic [chan_pkg::POS_W:0]              frame_blocks
);
    import chan_pkg::*;

    logic [POS_W:0] blk_cnt;
    logic [POS_W:0] cnt_next;
    logic           fe_hit;

    // delayed_frame_end stages reset high.
    assign fe_hit = delayed_run && delayed_frame_end;

    always_comb begin
        if (delayed_initialize) begin
            cnt_next = (POS_W + 1)'(1);
        end else begin
            cnt_next = blk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sym_valid  <= 1'b0;
            frame_done <= 1'b0;
            blk_cnt    <= '0;
        end else begin
            sym_valid  <= delayed_run;
            frame_done <= fe_hit;
            if (delayed_run) begin
                blk_cnt <= cnt_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (delayed_run) begin
            sym_word     <= final_symbols;  // lane 0 lands in the low bits.
            sym_position <= delayed_frame_position;
        end
        if (fe_hit) begin
            frame_blocks <= cnt_next;
        end
    end

endmodule

/* symbol_estimator_stub.sv */
`timescale 1ns/1ps

module symbol_estimator_stub (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sym_pkg::sample_block_t rse_vals,
    input  logic                   run,
    input  logic                   initialize,
    input  logic                   frame_end,
    input  chan_pkg::pos_t         frame_position,
    output sym_pkg::sym_block_t    final_symbols,
    output logic                   delayed_run,
    output logic                   delayed_initialize,
    output logic                   delayed_frame_end,
    output chan_pkg::pos_t         delayed_frame_position
);
    import chan_pkg::*;
    import sym_pkg::*;

    // rse_vals is kept on the port for a real trellis core, values are ignored here.

    sym_block_t         decision;
    sym_block_t         sym_dly;
    logic [H_DEPTH-1:0] run_sr;
    logic [H_DEPTH-1:0] init_sr;
    logic [H_DEPTH-1:0] fe_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < B_LEN; i++) begin
                decision[i] <= SYM_FIRST;
            end
            run_sr  <= '0;
            init_sr <= '0;
            fe_sr   <= '1;  // frame_end stages come up high.
        end else begin
            if (initialize) begin
                for (int i = 0; i < B_LEN; i++) begin
                    decision[i] <= SYM_FIRST;
                end
            end else if (run) begin
                for (int i = 0; i < B_LEN; i++) begin
                    decision[i] <= -decision[i];  // alternate sign per block.
                end
            end
            run_sr  <= {run_sr[H_DEPTH-2:0], run || initialize};
            init_sr <= {init_sr[H_DEPTH-2:0], initialize};
            fe_sr   <= {fe_sr[H_DEPTH-2:0], frame_end};
        end
    end

    // decision register is the first stage.
    delay_line #(
        .payload_t (sym_block_t),
        .DEPTH     (H_DEPTH - 1)
    ) u_sym_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (decision),
        .q     (sym_dly)
    );

    delay_line #(
        .payload_t (pos_t),
        .DEPTH     (H_DEPTH)
    ) u_pos_dly (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (frame_position),
        .q     (delayed_frame_position)
    );

    assign delayed_run        = run_sr[H_DEPTH-1];
    assign delayed_initialize = init_sr[H_DEPTH-1];
    assign delayed_frame_end  = fe_sr[H_DEPTH-1];

    assign final_symbols = (delayed_run || delayed_initialize) ? sym_dly : '0;

endmodule

/* tb_seq_est.sv */
`timescale 1ns/1ps

module tb_seq_est;
    import chan_pkg::*;
    import sym_pkg::*;

    localparam int CLK_PERIOD    = 10;
    localparam int WORD_W        = $bits(sym_block_t);
    localparam int SYM_W         = $bits(sym_t);
    localparam int LATENCY       = H_DEPTH + 2;  // last strobe to sym_valid.
    localparam int FRAME_SAMPLES = NUM_BLOCKS * B_LEN;
    localparam int RST_CYCLES    = 10;
    localparam int IDLE_CYCLES   = 20;
    localparam int EXTRA_SAMPLES = 12;
    localparam int ABORT_SAMPLES = 23;  // ends inside a block.
    localparam int MAX_GAP       = 3;
    localparam int DRAIN_CYCLES  = LATENCY + 4;
    localparam int STIM_CYCLES   = RST_CYCLES + IDLE_CYCLES + 2 * FRAME_SAMPLES
                                 + EXTRA_SAMPLES + 5
                                 + (FRAME_SAMPLES + ABORT_SAMPLES) * (MAX_GAP + 1)
                                 + DRAIN_CYCLES;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + H_DEPTH + 20;

    typedef struct {
        int                due;
        logic [WORD_W-1:0] word;
        pos_t              pos;
        bit                last;
    } exp_t;

    logic              clk;
    logic              rst_n;
    logic              sample_valid;
    sample_t           sample;
    logic              frame_start;
    logic              sym_valid;
    logic [WORD_W-1:0] sym_word;
    pos_t              sym_position;
    logic              frame_done;
    logic [POS_W:0]    frame_blocks;

    // expected outputs for the current cycle.
    logic              exp_valid;
    logic [WORD_W-1:0] exp_word;
    pos_t              exp_pos;
    logic              exp_done;
    logic [POS_W:0]    exp_blocks;

    exp_t   exp_q[$];
    integer seed = 32'heac6_c4a6;
    int     cyc;
    int     errors;
    int     blocks_seen;
    bit     m_in_frame;
    int     m_lane;
    int     m_blk;

    seq_est_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .frame_start  (frame_start),
        .sym_valid    (sym_valid),
        .sym_word     (sym_word),
        .sym_position (sym_position),
        .frame_done   (frame_done),
        .frame_blocks (frame_blocks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("MISMATCH %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    valid_chk: assert property (@(posedge clk) disable iff (!rst_n) sym_valid == exp_valid)
        else report_mismatch("sym_valid", $sampled(sym_valid), $sampled(exp_valid));
    word_chk: assert property (@(posedge clk) disable iff (!rst_n)
                               !exp_valid || sym_word == exp_word)
        else report_mismatch("sym_word", $sampled(sym_word), $sampled(exp_word));
    pos_chk: assert property (@(posedge clk) disable iff (!rst_n)
                              !exp_valid || sym_position == exp_pos)
        else report_mismatch("sym_position", $sampled(sym_position), $sampled(exp_pos));
    done_chk: assert property (@(posedge clk) disable iff (!rst_n) frame_done == exp_done)
        else report_mismatch("frame_done", $sampled(frame_done), $sampled(exp_done));
    blocks_chk: assert property (@(posedge clk) disable iff (!rst_n)
                                 !exp_done || frame_blocks == exp_blocks)
        else report_mismatch("frame_blocks", $sampled(frame_blocks), $sampled(exp_blocks));

    // +2 on every lane for block 0, sign flips each block after.
    function automatic logic [WORD_W-1:0] block_word(input int idx);
        sym_t              s;
        logic [WORD_W-1:0] w;
        s = (idx % 2 == 0) ? sym_t'(2) : sym_t'(-2);
        for (int l = 0; l < B_LEN; l++) begin
            w[l*SYM_W +: SYM_W] = s;  // lane 0 low.
        end
        return w;
    endfunction

    task automatic tick();
        @(negedge clk);
        cyc++;
        exp_valid = 1'b0;
        exp_done  = 1'b0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            exp_valid  = 1'b1;
            exp_word   = exp_q[0].word;
            exp_pos    = exp_q[0].pos;
            exp_done   = exp_q[0].last;
            exp_blocks = (POS_W + 1)'(NUM_BLOCKS);
            blocks_seen++;
            void'(exp_q.pop_front());
        end
    endtask

    task automatic idle_cycle();
        tick();
        sample_valid = 1'b0;
        frame_start  = 1'b0;
    endtask

    task automatic model_sample(input bit fs);
        exp_t e;
        if (fs) begin
            m_in_frame = 1'b1;
            m_lane     = 0;  // partial block is thrown away.
            m_blk      = 0;
        end
        if (m_in_frame) begin
            m_lane++;
            if (m_lane == B_LEN) begin
                e.due  = cyc + LATENCY;
                e.word = block_word(m_blk);
                e.pos  = pos_t'(m_blk);
                e.last = (m_blk == NUM_BLOCKS - 1);
                exp_q.push_back(e);
                m_lane = 0;
                m_blk++;
                if (m_blk == NUM_BLOCKS) begin
                    m_in_frame = 1'b0;
                end
            end
        end
    endtask

    task automatic send_samples(input bit start, input int count, input int max_gap);
        int gap;
        for (int i = 0; i < count; i++) begin
            gap = (max_gap > 0) ? {$random(seed)} % (max_gap + 1) : 0;
            repeat (gap) idle_cycle();
            tick();
            sample_valid = 1'b1;
            sample       = sample_t'($random(seed));
            frame_start  = start && (i == 0);
            model_sample(frame_start);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, stimulus did not finish", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        frame_start  = 1'b0;
        exp_valid    = 1'b0;
        exp_word     = '0;
        exp_pos      = '0;
        exp_done     = 1'b0;
        exp_blocks   = '0;
        cyc          = 0;
        errors       = 0;
        blocks_seen  = 0;
        m_in_frame   = 1'b0;
        m_lane       = 0;
        m_blk        = 0;
        repeat (RST_CYCLES) idle_cycle();
        rst_n = 1'b1;
        repeat (IDLE_CYCLES) idle_cycle();  // no output before a frame.

        send_samples(1'b1, FRAME_SAMPLES, 0);  // strobe every cycle.
        send_samples(1'b0, EXTRA_SAMPLES, 0);  // dropped, no frame open.
        repeat (5) idle_cycle();

        // back to back frames with gaps, second one cut short mid block.
        send_samples(1'b1, FRAME_SAMPLES, MAX_GAP);
        send_samples(1'b1, ABORT_SAMPLES, MAX_GAP);
        send_samples(1'b1, FRAME_SAMPLES, 0);
        repeat (DRAIN_CYCLES) idle_cycle();

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected blocks never came out of the DUT", exp_q.size());
        end
        $display("blocks checked: %0d, errors: %0d", blocks_seen, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
